/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN 32
`define REG_AW 5
`define IQ_DEPTH 8
`define OQ_DEPTH 4
`define BOOT_PC 32'h0000_0000

`endif

/* source/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

	typedef enum logic [5:0] {
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL,
		OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC,
		OP_BEQ, OP_BGEZ, OP_BGEZAL, OP_BGTZ, OP_BLEZ, OP_BLTZ,
		OP_BLTZAL, OP_BNE, OP_J, OP_JAL, OP_JALR, OP_JR,
		OP_MOVZ, OP_MOVN,
		OP_CACHE, OP_ERET, OP_MFC0, OP_MTC0, OP_TLBP, OP_TLBR,
		OP_TLBWI, OP_TLBWR, OP_WAIT,
		OP_MUL, OP_SSNOP, OP_ALU
	} oper_t;

	typedef struct packed {
		logic              we;
		logic [`REG_AW-1:0] waddr;
	} reg_wr_t;

	typedef struct packed {
		oper_t              op;
		logic [`REG_AW-1:0] reg_addr1;
		logic [`REG_AW-1:0] reg_addr2;
		logic               delayslot;
	} pipeline_data_t;

	typedef struct packed {
		reg_wr_t reg_wr;
	} pipeline_req_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] inst;
	} fetch_entry_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] inst_a;
		logic [`CPU_XLEN-1:0] inst_b;
		logic                 dual;
	} issue_rec_t;

	// operation classes shared by the pairing check and the issue control
	function automatic logic is_load(input oper_t op);
		return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL};
	endfunction

	function automatic logic is_store(input oper_t op);
		return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC};
	endfunction

	function automatic logic is_jump(input oper_t op);
		return op inside {OP_BEQ, OP_BGEZ, OP_BGEZAL, OP_BGTZ, OP_BLEZ, OP_BLTZ,
			OP_BLTZAL, OP_BNE, OP_J, OP_JAL, OP_JALR, OP_JR};
	endfunction

	function automatic logic is_cond_move(input oper_t op);
		return op inside {OP_MOVZ, OP_MOVN};
	endfunction

	function automatic logic is_privileged(input oper_t op);
		return op inside {OP_CACHE, OP_ERET, OP_MFC0, OP_MTC0, OP_TLBP, OP_TLBR,
			OP_TLBWI, OP_TLBWR, OP_WAIT};
	endfunction

endpackage

/* source/fifo_if.sv */
`timescale 1ns/1ps

interface fifo_if #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 8
);
	logic                         push;
	T                             push_data;
	logic                         full;
	// entries removed this cycle, 0 to 2
	logic [1:0]                   pop_count;
	logic [$clog2(DEPTH+1)-1:0]   count;
	T                             head0;
	T                             head1;

	modport writer (output push, output push_data, input full);
	modport reader (output pop_count, input count, input head0, input head1);
	modport owner (
		input  push, input push_data, input pop_count,
		output full, output count, output head0, output head1
	);
endinterface

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 8
) (
	input logic   clk,
	input logic   rst,
	fifo_if.owner w,
	fifo_if.owner r
);
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	T              mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] cnt;
	logic          push_ok;

	assign push_ok = w.push && !w.full;
	assign w.full = (cnt == CW'(DEPTH));
	assign r.count = cnt;
	// two oldest entries, head1 only meaningful when count >= 2
	assign r.head0 = mem[rd_ptr];
	assign r.head1 = mem[rd_ptr + PW'(1)];

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_ptr] <= w.push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + PW'(1);
			rd_ptr <= rd_ptr + PW'(r.pop_count);
			cnt    <= cnt + CW'(push_ok) - CW'(r.pop_count);
		end
	end
endmodule

/* source/wb_fetch.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module wb_fetch (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic [`CPU_XLEN-1:0] wb_adr,
	input  logic [`CPU_XLEN-1:0] wb_rdata,
	input  logic                 wb_ack,
	fifo_if.writer               iq
);
	logic                 cyc_q;
	logic [`CPU_XLEN-1:0] pc_q;
	logic                 done;

	assign done = cyc_q && wb_ack;

	assign wb_cyc = cyc_q;
	assign wb_stb = cyc_q;
	assign wb_adr = pc_q;

	// the word lands in the queue in the ack cycle
	assign iq.push = done;
	assign iq.push_data = cpu_pkg::fetch_entry_t'{addr: pc_q, inst: wb_rdata};

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_q <= 1'b0;
			pc_q  <= `BOOT_PC;
		end else if (done) begin
			cyc_q <= 1'b0;
			pc_q  <= pc_q + `CPU_XLEN'(4);
		end else if (!cyc_q && !iq.full) begin
			// only this master fills the queue, so room stays until ack
			cyc_q <= 1'b1;
		end
	end
endmodule

/* source/mips_decoder.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module mips_decoder (
	input  logic [`CPU_XLEN-1:0]    inst,
	output cpu_pkg::pipeline_data_t data,
	output cpu_pkg::pipeline_req_t  req
);
	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;

	assign opcode = inst[31:26];
	assign funct  = inst[5:0];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];

	always_comb begin
		data.op        = cpu_pkg::OP_ALU;
		data.reg_addr1 = rs;
		data.reg_addr2 = rt;
		data.delayslot = 1'b0;
		// immediate forms write rt unless changed below
		req.reg_wr.we    = 1'b1;
		req.reg_wr.waddr = rt;
		case (opcode)
		6'h00: begin
			req.reg_wr.waddr = rd;
			case (funct)
			6'h00: data.op = (inst == 32'h0000_0040) ? cpu_pkg::OP_SSNOP : cpu_pkg::OP_ALU;
			6'h08: begin
				data.op       = cpu_pkg::OP_JR;
				req.reg_wr.we = 1'b0;
			end
			6'h09: data.op = cpu_pkg::OP_JALR;
			6'h0a: data.op = cpu_pkg::OP_MOVZ;
			6'h0b: data.op = cpu_pkg::OP_MOVN;
			default: data.op = cpu_pkg::OP_ALU;
			endcase
		end
		6'h01: begin
			// regimm branches, link forms write r31
			case (rt)
			5'h00: data.op = cpu_pkg::OP_BLTZ;
			5'h10: data.op = cpu_pkg::OP_BLTZAL;
			5'h11: data.op = cpu_pkg::OP_BGEZAL;
			default: data.op = cpu_pkg::OP_BGEZ;
			endcase
			req.reg_wr.we    = rt[4];
			req.reg_wr.waddr = `REG_AW'(31);
		end
		6'h02, 6'h04, 6'h05, 6'h06, 6'h07: begin
			case (opcode)
			6'h02: data.op = cpu_pkg::OP_J;
			6'h04: data.op = cpu_pkg::OP_BEQ;
			6'h05: data.op = cpu_pkg::OP_BNE;
			6'h06: data.op = cpu_pkg::OP_BLEZ;
			default: data.op = cpu_pkg::OP_BGTZ;
			endcase
			req.reg_wr.we = 1'b0;
		end
		6'h03: begin
			data.op          = cpu_pkg::OP_JAL;
			req.reg_wr.waddr = `REG_AW'(31);
		end
		6'h10: begin
			req.reg_wr.we = 1'b0;
			if (inst[25]) begin
				case (funct)
				6'h01: data.op = cpu_pkg::OP_TLBR;
				6'h02: data.op = cpu_pkg::OP_TLBWI;
				6'h06: data.op = cpu_pkg::OP_TLBWR;
				6'h08: data.op = cpu_pkg::OP_TLBP;
				6'h18: data.op = cpu_pkg::OP_ERET;
				default: data.op = cpu_pkg::OP_WAIT;
				endcase
			end else if (rs == 5'h00) begin
				data.op       = cpu_pkg::OP_MFC0;
				req.reg_wr.we = 1'b1;
			end else begin
				data.op = cpu_pkg::OP_MTC0;
			end
		end
		6'h1c: begin
			req.reg_wr.waddr = rd;
			if (funct == 6'h02)
				data.op = cpu_pkg::OP_MUL;
		end
		6'h20: data.op = cpu_pkg::OP_LB;
		6'h21: data.op = cpu_pkg::OP_LH;
		6'h22: data.op = cpu_pkg::OP_LWL;
		6'h23: data.op = cpu_pkg::OP_LW;
		6'h24: data.op = cpu_pkg::OP_LBU;
		6'h25: data.op = cpu_pkg::OP_LHU;
		6'h26: data.op = cpu_pkg::OP_LWR;
		6'h30: data.op = cpu_pkg::OP_LL;
		6'h38: data.op = cpu_pkg::OP_SC;
		6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e, 6'h2f: begin
			case (opcode)
			6'h28: data.op = cpu_pkg::OP_SB;
			6'h29: data.op = cpu_pkg::OP_SH;
			6'h2a: data.op = cpu_pkg::OP_SWL;
			6'h2b: data.op = cpu_pkg::OP_SW;
			6'h2e: data.op = cpu_pkg::OP_SWR;
			default: data.op = cpu_pkg::OP_CACHE;
			endcase
			req.reg_wr.we = 1'b0;
		end
		default: data.op = cpu_pkg::OP_ALU;
		endcase
	end
endmodule

/* source/superscalar_ctrl.sv */
`timescale 1ns/1ps

module superscalar_ctrl (
	input  logic                    rst,
	input  logic                    ena,
	input  cpu_pkg::pipeline_data_t data_a,
	input  cpu_pkg::pipeline_data_t data_b,
	input  cpu_pkg::pipeline_req_t  req_a,
	input  cpu_pkg::pipeline_req_t  req_b,
	output logic                    inst2_taken
);
	logic load_a;
	logic mem_a;
	logic mem_b;
	logic jump_a;
	logic jump_b;
	logic priv_a;
	logic priv_b;
	logic cmov_b;
	logic ssnop;
	logic raw_dep;

	assign load_a = cpu_pkg::is_load(data_a.op);
	assign mem_a  = load_a || cpu_pkg::is_store(data_a.op);
	assign mem_b  = cpu_pkg::is_load(data_b.op) || cpu_pkg::is_store(data_b.op);
	assign jump_a = cpu_pkg::is_jump(data_a.op);
	assign jump_b = cpu_pkg::is_jump(data_b.op);
	assign priv_a = cpu_pkg::is_privileged(data_a.op);
	assign priv_b = cpu_pkg::is_privileged(data_b.op);
	assign cmov_b = cpu_pkg::is_cond_move(data_b.op);
	assign ssnop  = (data_a.op == cpu_pkg::OP_SSNOP) || (data_b.op == cpu_pkg::OP_SSNOP);

	// a writes a nonzero register that b reads
	assign raw_dep = req_a.reg_wr.we && (req_a.reg_wr.waddr != '0) &&
		((req_a.reg_wr.waddr == data_b.reg_addr1) ||
		 (req_a.reg_wr.waddr == data_b.reg_addr2));

	always_comb begin
		if (rst || !ena) begin
			inst2_taken = 1'b0;
		end else if (ssnop) begin
			// ssnop forces single issue by definition
			inst2_taken = 1'b0;
		end else if (cmov_b && raw_dep) begin
			// movz/movn need the operand before a has produced it
			inst2_taken = 1'b0;
		end else if (jump_a || jump_b) begin
			// jumps only in slot a, and their delay slot goes to slot a next
			inst2_taken = 1'b0;
		end else if (data_a.delayslot) begin
			inst2_taken = 1'b0;
		end else if (mem_a && mem_b) begin
			// one memory port
			inst2_taken = 1'b0;
		end else if (load_a && raw_dep) begin
			inst2_taken = 1'b0;
		end else if (priv_a || priv_b) begin
			// cp0 access lives in pipe a alone
			inst2_taken = 1'b0;
		end else if ((data_a.op == cpu_pkg::OP_MUL) && raw_dep) begin
			// mul result is two cycles late
			inst2_taken = 1'b0;
		end else begin
			// b may write the same register as a since slot b retires last
			inst2_taken = 1'b1;
		end
	end
endmodule

/* source/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ena,
	fifo_if.reader                  iq,
	fifo_if.writer                  oq,
	output cpu_pkg::pipeline_data_t data_a,
	output cpu_pkg::pipeline_data_t data_b,
	output cpu_pkg::pipeline_req_t  req_a,
	output cpu_pkg::pipeline_req_t  req_b,
	input  logic                    inst2_taken
);
	cpu_pkg::pipeline_data_t dec_a;
	// last issued slot a was a jump, so the next slot a is its delay slot
	logic                    in_delay;
	logic                    fire;

	mips_decoder u_dec_a (
		.inst (iq.head0.inst),
		.data (dec_a),
		.req  (req_a)
	);

	mips_decoder u_dec_b (
		.inst (iq.head1.inst),
		.data (data_b),
		.req  (req_b)
	);

	always_comb begin
		data_a           = dec_a;
		data_a.delayslot = in_delay;
	end

	// wait for two words so the pairing decision never depends on bus timing
	assign fire = ena && (iq.count >= 2) && !oq.full;

	assign iq.pop_count = !fire ? 2'd0 : (inst2_taken ? 2'd2 : 2'd1);
	assign oq.push = fire;
	assign oq.push_data = cpu_pkg::issue_rec_t'{
		pc:     iq.head0.addr,
		inst_a: iq.head0.inst,
		inst_b: inst2_taken ? iq.head1.inst : '0,
		dual:   inst2_taken
	};

	always_ff @(posedge clk) begin
		if (rst)
			in_delay <= 1'b0;
		else if (fire)
			in_delay <= cpu_pkg::is_jump(dec_a.op);
	end
endmodule

/* source/issue_stage_top.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module issue_stage_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ena,
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic [`CPU_XLEN-1:0] wb_adr,
	input  logic [`CPU_XLEN-1:0] wb_rdata,
	input  logic                 wb_ack,
	output logic                 issue_valid,
	input  logic                 issue_ready,
	output logic [`CPU_XLEN-1:0] issue_pc,
	output logic [`CPU_XLEN-1:0] issue_inst_a,
	output logic [`CPU_XLEN-1:0] issue_inst_b,
	output logic                 issue_dual
);
	cpu_pkg::pipeline_data_t data_a;
	cpu_pkg::pipeline_data_t data_b;
	cpu_pkg::pipeline_req_t  req_a;
	cpu_pkg::pipeline_req_t  req_b;
	logic                    inst2_taken;

	fifo_if #(.T(cpu_pkg::fetch_entry_t), .DEPTH(`IQ_DEPTH)) iq_if ();
	fifo_if #(.T(cpu_pkg::issue_rec_t), .DEPTH(`OQ_DEPTH)) oq_if ();

	wb_fetch u_fetch (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack,
		.iq (iq_if.writer)
	);

	sync_fifo #(.T(cpu_pkg::fetch_entry_t), .DEPTH(`IQ_DEPTH)) u_iq (
		.clk, .rst, .w (iq_if.owner), .r (iq_if.owner)
	);

	sync_fifo #(.T(cpu_pkg::issue_rec_t), .DEPTH(`OQ_DEPTH)) u_oq (
		.clk, .rst, .w (oq_if.owner), .r (oq_if.owner)
	);

	issue_ctrl u_issue (
		.clk, .rst, .ena, .iq (iq_if.reader), .oq (oq_if.writer),
		.data_a, .data_b, .req_a, .req_b, .inst2_taken
	);

	superscalar_ctrl u_pair (
		.rst, .ena, .data_a, .data_b, .req_a, .req_b, .inst2_taken
	);

	// output side drains the oldest record
	assign issue_valid = (oq_if.count != '0);
	assign issue_pc = oq_if.head0.pc;
	assign issue_inst_a = oq_if.head0.inst_a;
	assign issue_inst_b = oq_if.head0.inst_b;
	assign issue_dual = oq_if.head0.dual;
	assign oq_if.pop_count = (issue_valid && issue_ready) ? 2'd1 : 2'd0;
endmodule

/* test/issue_props.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module issue_props (
	input logic                 clk,
	input logic                 rst,
	input logic                 wb_cyc,
	input logic                 wb_stb,
	input logic [`CPU_XLEN-1:0] wb_adr,
	input logic                 wb_ack,
	input logic                 issue_valid,
	input logic                 issue_ready,
	input logic [`CPU_XLEN-1:0] issue_pc,
	input logic [`CPU_XLEN-1:0] issue_inst_a,
	input logic [`CPU_XLEN-1:0] issue_inst_b,
	input logic                 issue_dual
);
	// request held with the same address until the slave acks
	assert property (@(posedge clk) disable iff (rst)
		wb_cyc && wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
		else $error("wishbone request dropped or address changed before ack");

	// stalled record must not change
	assert property (@(posedge clk) disable iff (rst)
		issue_valid && !issue_ready |=> issue_valid &&
		$stable({issue_pc, issue_inst_a, issue_inst_b, issue_dual}))
		else $error("issue record changed while stalled");

	assert property (@(posedge clk) rst |=> !issue_valid && !wb_cyc)
		else $error("output valid or bus active during reset");
endmodule

bind issue_stage_top issue_props u_props (
	.clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_ack,
	.issue_valid, .issue_ready, .issue_pc, .issue_inst_a, .issue_inst_b, .issue_dual
);

/* test/tb_issue_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_issue_stage;
	logic                 clk;
	logic                 rst;
	logic                 ena;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic [`CPU_XLEN-1:0] wb_adr;
	logic [`CPU_XLEN-1:0] wb_rdata;
	logic                 wb_ack;
	logic                 issue_valid;
	logic                 issue_ready;
	logic [`CPU_XLEN-1:0] issue_pc;
	logic [`CPU_XLEN-1:0] issue_inst_a;
	logic [`CPU_XLEN-1:0] issue_inst_b;
	logic                 issue_dual;

	logic [31:0] gold [0:255];
	logic [31:0] prog [0:63];
	int          n_mem;
	int          n_exp;
	int          exp_base;
	int          rec_idx;
	int          cycles;
	int          cycle_limit;
	int          ena_hold;
	int          wait_left;
	bit          busy;
	bit          stress;
	bit          rdy;

	issue_stage_top u_issue_stage_top (.*);

	always #2 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s: got %h expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	task automatic load_golden();
		int i;
		$readmemh("test/issue_golden.txt", gold);
		if ($isunknown(gold[0])) begin
			$display("could not read the golden file test/issue_golden.txt");
			$display("RESULT: FAIL");
			$fatal(1, "no golden data");
		end
		n_mem = gold[0];
		for (i = 0; i < 64; i++)
			prog[i] = 32'h0000_0000;
		for (i = 0; i < n_mem; i++)
			prog[gold[1 + 2 * i][7:2]] = gold[2 + 2 * i];
		n_exp = gold[1 + 2 * n_mem];
		exp_base = 2 + 2 * n_mem;
	endtask

	// words past the program are sll r0,r0,0 no-ops
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (addr[31:8] == '0)
			return prog[addr[7:2]];
		return 32'h0000_0000;
	endfunction

	task automatic check_record(input int idx);
		int base;
		base = exp_base + 4 * idx;
		check_value($sformatf("record %0d pc", idx), issue_pc, gold[base]);
		check_value($sformatf("record %0d inst_a", idx), issue_inst_a, gold[base + 1]);
		check_value($sformatf("record %0d inst_b", idx), issue_inst_b, gold[base + 2]);
		check_value($sformatf("record %0d dual", idx), {31'b0, issue_dual}, gold[base + 3]);
	endtask

	task automatic run_phase(input bit with_stalls);
		rst <= 1'b1;
		@(negedge clk);
		stress = with_stalls;
		rec_idx = 0;
		repeat (3) @(negedge clk);
		rst <= 1'b0;
		wait (rec_idx == n_exp);
	endtask

	// wishbone slave with 0 to 3 wait states per transfer
	always @(negedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			busy = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = $urandom_range(0, 3);
			end
			if (wait_left == 0) begin
				wb_ack <= 1'b1;
				wb_rdata <= read_word(wb_adr);
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	// the record is checked while it is stable before the accepting edge
	always @(negedge clk) begin
		if (rst) begin
			issue_ready <= 1'b0;
			ena <= 1'b0;
			ena_hold = 0;
		end else begin
			rdy = (rec_idx < n_exp) && (!stress || $urandom_range(0, 3) != 0);
			issue_ready <= rdy;
			if (ena_hold == 0) begin
				ena <= !stress || ($urandom_range(0, 2) != 0);
				ena_hold = $urandom_range(1, 8);
			end else begin
				ena_hold--;
			end
			if (issue_valid && rdy) begin
				check_record(rec_idx);
				rec_idx++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: issue records did not all arrive within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ena = 1'b0;
		wb_ack = 1'b0;
		wb_rdata = '0;
		issue_ready = 1'b0;
		stress = 1'b0;
		rec_idx = 0;
		cycles = 0;
		void'($urandom(46));
		load_golden();
		// two runs over the same record list plus reset time
		cycle_limit = 2 * 40 * n_exp + 40;
		run_phase(1'b0);
		run_phase(1'b1);
		$display("checked %0d issue records in two runs", 2 * n_exp);
		$display("RESULT: PASS");
		$finish;
	end
endmodule

/* test/issue_golden.txt */
// memory: a count line, then one line per word as address and instruction
// expected: a count line, then one line per record as pc, inst_a, inst_b and dual
0000001a
00000000 24010001
00000004 24020002
00000008 24030003
0000000c 24040004
00000010 08000008
00000014 24050005
00000018 24060006
0000001c 24070007
00000020 8c280000
00000024 01024821
00000028 240a000a
0000002c 8c200004
00000030 00035821
00000034 ac230000
00000038 8c2c0004
0000003c 400d6000
00000040 00000040
00000044 240e000e
00000048 01c1780a
0000004c 24110011
00000050 70228002
00000054 02009021
00000058 10000002
0000005c 24130013
00000060 24140014
00000064 24150015
00000014
00000000 24010001 24020002 00000001
00000008 24030003 24040004 00000001
00000010 08000008 00000000 00000000
00000014 24050005 00000000 00000000
00000018 24060006 24070007 00000001
00000020 8c280000 00000000 00000000
00000024 01024821 240a000a 00000001
0000002c 8c200004 00035821 00000001
00000034 ac230000 00000000 00000000
00000038 8c2c0004 00000000 00000000
0000003c 400d6000 00000000 00000000
00000040 00000040 00000000 00000000
00000044 240e000e 00000000 00000000
00000048 01c1780a 24110011 00000001
00000050 70228002 00000000 00000000
00000054 02009021 00000000 00000000
00000058 10000002 00000000 00000000
0000005c 24130013 00000000 00000000
00000060 24140014 24150015 00000001
00000068 00000000 00000000 00000001

/* tb.f */
+incdir+source
source/cpu_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/wb_fetch.sv
source/mips_decoder.sv
source/superscalar_ctrl.sv
source/issue_ctrl.sv
source/issue_stage_top.sv
test/issue_props.sv
test/tb_issue_stage.sv
